/* include/his_macros.svh */
`ifndef HIS_MACROS_SVH
`define HIS_MACROS_SVH

// bin address width, addresses 48..63 count as overflow
`define HIS_NB 6

// number of real bins in the count memory
`define HIS_NUM_BINS 48

// width of one bin count and of the overflow counter
`define HIS_COUNT_W 21

// acquisition window length in clock cycles
// must stay below 2**HIS_COUNT_W so a bin can never wrap
`define HIS_ACQ_CYCLES 40

`endif

/* rtl/hisDataPkg.sv */
`default_nettype none

`include "his_macros.svh"

package hisDataPkg;

    // one registered hit on its way to the accumulator
    typedef struct packed {
        logic              valid;
        logic [`HIS_NB-1:0] addr;
    } hitT;

    // one word of the histogram sweep
    typedef struct packed {
        logic [`HIS_NB-1:0]      idx;   // bin index
        logic [`HIS_COUNT_W-1:0] count; // hits in that bin
    } binWordT;

endpackage

`default_nettype wire

/* rtl/hisCtrlPkg.sv */
`default_nettype none

package hisCtrlPkg;

    // acquisition side, DRAIN also covers the readout sweep
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ACQ   = 2'd1,
        DRAIN = 2'd2
    } acqStateT;

    // readout sweep control
    typedef enum logic {
        RD_IDLE  = 1'b0,
        RD_SWEEP = 1'b1
    } rdStateT;

endpackage

`default_nettype wire

/* rtl/binAddrCapture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "his_macros.svh"

module binAddrCapture (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    hitValid,
    input  logic [`HIS_NB-1:0]      hitAddr,
    input  logic                    acqOpen,
    input  logic                    acqBegin,
    output hisDataPkg::hitT         hit,
    output logic [`HIS_COUNT_W-1:0] ovfCount
);
    import hisDataPkg::*;

    logic isOvf;
    logic take; // strobe seen inside the window
    hitT  hitNext;

    assign isOvf = hitAddr >= `HIS_NB'(`HIS_NUM_BINS);
    assign take  = hitValid & acqOpen;

    always_comb begin
        hitNext.valid = take & ~isOvf; // overflow hits never reach the memory
        hitNext.addr  = hitAddr;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit <= '0;
        end else begin
            hit <= hitNext;
        end
    end

    // first window cycle restarts the count but may itself carry an overflow hit
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ovfCount <= '0;
        end else if (acqBegin) begin
            ovfCount <= (take & isOvf) ? `HIS_COUNT_W'(1) : '0;
        end else if (take & isOvf) begin
            ovfCount <= ovfCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/hisAccumulator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "his_macros.svh"

module hisAccumulator (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    acqStart,
    input  hisDataPkg::hitT         hit,
    input  logic [`HIS_NB-1:0]      rdAddr,
    input  logic                    readDone,
    output logic                    acqOpen,
    output logic                    acqBegin,
    output logic                    readStart,
    output logic                    nextFlag,
    output logic [`HIS_COUNT_W-1:0] rdCount
);
    import hisCtrlPkg::*;

    localparam int CntW = $clog2(`HIS_ACQ_CYCLES);

    acqStateT                acqState;
    logic [CntW-1:0]         acqCnt;
    logic                    lastCycle;
    logic [`HIS_NUM_BINS-1:0] touched;  // bin written in this window
    logic [`HIS_COUNT_W-1:0] binMem [`HIS_NUM_BINS];
    logic [`HIS_COUNT_W-1:0] curCount;

    assign lastCycle = acqCnt == CntW'(`HIS_ACQ_CYCLES - 1);
    assign acqOpen   = acqState == ACQ;
    assign acqBegin  = acqOpen && acqCnt == '0;

    // window control
    // in DRAIN acqCnt only marks whether the flush cycle is over
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acqState  <= IDLE;
            acqCnt    <= '0;
            readStart <= 1'b0;
            nextFlag  <= 1'b0;
        end else begin
            readStart <= 1'b0;
            case (acqState)
                IDLE: begin
                    if (acqStart) begin
                        acqState <= ACQ;
                        acqCnt   <= '0;
                    end
                end
                ACQ: begin
                    if (lastCycle) begin
                        acqState <= DRAIN;
                        acqCnt   <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end
                DRAIN: begin
                    if (acqCnt == '0) begin // last hit written at this edge
                        acqCnt    <= CntW'(1);
                        readStart <= 1'b1;
                        nextFlag  <= ~nextFlag;
                    end else if (readDone) begin
                        acqState <= IDLE;
                        acqCnt   <= '0;
                    end
                end
                default: begin
                    acqState <= IDLE;
                    acqCnt   <= '0;
                end
            endcase
        end
    end

    // lazy clear, one flag per bin instead of wiping the memory
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            touched <= '0;
        end else if (acqBegin) begin
            touched <= '0;
        end else if (hit.valid) begin
            touched[hit.addr] <= 1'b1;
        end
    end

    // read-modify-write in one cycle, a back-to-back hit sees the fresh value
    assign curCount = binMem[hit.addr];

    always_ff @(posedge clk) begin
        if (hit.valid) begin
            if (touched[hit.addr]) begin
                binMem[hit.addr] <= curCount + 1'b1;
            end else begin
                binMem[hit.addr] <= `HIS_COUNT_W'(1); // first hit initializes
            end
        end
    end

    // readout port, stale content of untouched bins is hidden
    assign rdCount = touched[rdAddr] ? binMem[rdAddr] : '0;

endmodule

`default_nettype wire

/* rtl/hisReadout.sv */
`timescale 1ns/1ps
`default_nettype none

`include "his_macros.svh"

module hisReadout (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    readStart,
    input  logic [`HIS_COUNT_W-1:0] rdCount,
    output logic [`HIS_NB-1:0]      rdAddr,
    output hisDataPkg::binWordT     binOut,
    output logic                    binValid,
    output logic                    hisDone,
    output logic                    readDone
);
    import hisCtrlPkg::*;

    localparam logic [`HIS_NB-1:0] LastBin = `HIS_NB'(`HIS_NUM_BINS - 1);

    rdStateT rdState;
    logic    emit;  // a word is latched at this edge
    logic    atLast;

    // rdAddr rests at 0, so bin 0 goes out right on readStart
    assign emit   = (rdState == RD_SWEEP) || readStart;
    assign atLast = rdAddr == LastBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdState  <= RD_IDLE;
            rdAddr   <= '0;
            binValid <= 1'b0;
            hisDone  <= 1'b0;
        end else begin
            hisDone  <= binValid && binOut.idx == LastBin; // one cycle behind last word
            binValid <= emit;
            case (rdState)
                RD_IDLE: begin
                    if (readStart) begin
                        rdState <= RD_SWEEP;
                        rdAddr  <= `HIS_NB'(1);
                    end
                end
                RD_SWEEP: begin
                    if (atLast) begin
                        rdState <= RD_IDLE;
                        rdAddr  <= '0;
                    end else begin
                        rdAddr <= rdAddr + 1'b1;
                    end
                end
                default: rdState <= RD_IDLE;
            endcase
        end
    end

    // payload only, qualified by binValid
    always_ff @(posedge clk) begin
        if (emit) begin
            binOut.idx   <= rdAddr;
            binOut.count <= rdCount;
        end
    end

    // accumulator leaves DRAIN together with the done pulse
    assign readDone = hisDone;

endmodule

`default_nettype wire

/* rtl/hisBuilder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "his_macros.svh"

module hisBuilder (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    acqStart,
    input  logic                    hitValid,
    input  logic [`HIS_NB-1:0]      hitAddr,
    output hisDataPkg::binWordT     binOut,
    output logic                    binValid,
    output logic                    hisDone,
    output logic                    nextFlag,
    output logic [`HIS_COUNT_W-1:0] ovfCount
);
    import hisDataPkg::*;

    hitT                     hit;
    logic                    acqOpen;
    logic                    acqBegin;
    logic                    readStart;
    logic                    readDone;
    logic [`HIS_NB-1:0]      rdAddr;
    logic [`HIS_COUNT_W-1:0] rdCount;

    binAddrCapture binAddrCapture_i (
        .clk      (clk),
        .res      (res),
        .hitValid (hitValid),
        .hitAddr  (hitAddr),
        .acqOpen  (acqOpen),
        .acqBegin (acqBegin),
        .hit      (hit),
        .ovfCount (ovfCount)
    );

    hisAccumulator hisAccumulator_i (
        .clk       (clk),
        .res       (res),
        .acqStart  (acqStart),
        .hit       (hit),
        .rdAddr    (rdAddr),
        .readDone  (readDone),
        .acqOpen   (acqOpen),
        .acqBegin  (acqBegin),
        .readStart (readStart),
        .nextFlag  (nextFlag),
        .rdCount   (rdCount)
    );

    hisReadout hisReadout_i (
        .clk       (clk),
        .res       (res),
        .readStart (readStart),
        .rdCount   (rdCount),
        .rdAddr    (rdAddr),
        .binOut    (binOut),
        .binValid  (binValid),
        .hisDone   (hisDone),
        .readDone  (readDone)
    );

endmodule

`default_nettype wire

/* dv/hisBuilder_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module hisBuilder_chk (
    input logic clk,
    input logic res,
    input logic binValid,
    input logic hisDone,
    input logic nextFlag
);

    // done comes one cycle after the last word, never with it
    noWordWithDone: assert property (@(posedge clk) disable iff (!res)
        !(binValid && hisDone))
        else $error("binValid and hisDone high in the same cycle");

    doneIsPulse: assert property (@(posedge clk) disable iff (!res)
        hisDone |=> !hisDone)
        else $error("hisDone stayed high for more than one cycle");

    // flag flips right before the sweep starts
    flagBeforeSweep: assert property (@(posedge clk) disable iff (!res)
        $changed(nextFlag) |=> $rose(binValid))
        else $error("nextFlag changed without a sweep starting in the next cycle");

endmodule

bind hisBuilder hisBuilder_chk hisBuilder_chk_i (
    .clk      (clk),
    .res      (res),
    .binValid (binValid),
    .hisDone  (hisDone),
    .nextFlag (nextFlag)
);

`default_nettype wire

/* dv/hisBuilderTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "his_macros.svh"

module hisBuilderTb;
    import hisDataPkg::*;

    localparam int NumWin    = 3;
    localparam int NumRows   = NumWin * `HIS_ACQ_CYCLES;
    localparam int TimeLimit = NumWin * (`HIS_ACQ_CYCLES + `HIS_NUM_BINS + 10) + 20;

    // one window cycle of stimulus
    typedef struct packed {
        logic               strobe;
        logic [`HIS_NB-1:0] addr;
    } stimRowT;

    logic                    clk;
    logic                    res;
    logic                    acqStart;
    logic                    hitValid;
    logic [`HIS_NB-1:0]      hitAddr;
    binWordT                 binOut;
    logic                    binValid;
    logic                    hisDone;
    logic                    nextFlag;
    logic [`HIS_COUNT_W-1:0] ovfCount;

    stimRowT     stimTab [NumRows];
    int unsigned expCount [`HIS_NUM_BINS];
    int unsigned expOvf;
    int          cycleCnt = 0;

    hisBuilder hisBuilder_i (
        .clk      (clk),
        .res      (res),
        .acqStart (acqStart),
        .hitValid (hitValid),
        .hitAddr  (hitAddr),
        .binOut   (binOut),
        .binValid (binValid),
        .hisDone  (hisDone),
        .nextFlag (nextFlag),
        .ovfCount (ovfCount)
    );

    always #50 clk = ~clk;

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic expectValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp)
            else stopOnError($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
    endtask

    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt >= TimeLimit) begin
            stopOnError($sformatf("timeout, run did not end within %0d cycles", TimeLimit));
        end
    end

    task automatic setRow(input int idx, input int addr);
        stimTab[idx].strobe = 1'b1;
        stimTab[idx].addr   = `HIS_NB'(addr);
    endtask

    task automatic fillTable();
        int base;
        for (int w = 0; w < NumWin; w++) begin
            base = w * `HIS_ACQ_CYCLES;
            for (int r = 0; r < `HIS_ACQ_CYCLES; r++) begin
                stimTab[base + r].strobe = ($urandom % 4) != 0;
                if (w == 1) begin
                    stimTab[base + r].addr = `HIS_NB'(24 + $urandom % 40); // upper bins only
                end else begin
                    stimTab[base + r].addr = `HIS_NB'($urandom % 64);
                end
            end
        end
        for (int r = 0; r < 5; r++) begin
            setRow(r, 5); // same bin back to back
        end
        setRow(5, 48);
        setRow(6, 63);
        setRow(7, 50);
        setRow(`HIS_ACQ_CYCLES, 63); // overflow on the first window cycle
        for (int r = 1; r < 4; r++) begin
            setRow(`HIS_ACQ_CYCLES + r, 24);
        end
        base = 2 * `HIS_ACQ_CYCLES;
        setRow(base, 0);
        setRow(base + 1, 0);
        setRow(base + 20, 48);
        setRow(base + `HIS_ACQ_CYCLES - 2, 47);
        setRow(base + `HIS_ACQ_CYCLES - 1, 47); // last bin on the last window cycle
    endtask

    // expected histogram from the table alone
    task automatic buildModel(input int w);
        stimRowT row;
        expOvf = 0;
        for (int b = 0; b < `HIS_NUM_BINS; b++) begin
            expCount[b] = 0;
        end
        for (int r = 0; r < `HIS_ACQ_CYCLES; r++) begin
            row = stimTab[w * `HIS_ACQ_CYCLES + r];
            if (row.strobe) begin
                if (row.addr < `HIS_NUM_BINS) expCount[row.addr]++;
                else expOvf++;
            end
        end
    endtask

    task automatic runWindow(input int w);
        stimRowT            row;
        int                 wordCnt;
        logic               prevValid;
        logic [`HIS_NB-1:0] prevIdx;
        logic               done;
        logic               flagBefore;
        flagBefore = logic'(w % 2);
        expectValue("nextFlag", 32'(flagBefore), 32'(nextFlag));
        @(posedge clk);
        #5;
        acqStart = 1'b1;
        hitValid = 1'b1; // window not open yet
        hitAddr  = `HIS_NB'(7);
        for (int r = 0; r < `HIS_ACQ_CYCLES; r++) begin
            row = stimTab[w * `HIS_ACQ_CYCLES + r];
            @(posedge clk);
            #5;
            acqStart = 1'b0;
            hitValid = row.strobe;
            hitAddr  = row.addr;
        end
        @(posedge clk);
        #5;
        hitValid = 1'b1; // just after the window
        hitAddr  = `HIS_NB'(7);
        wordCnt   = 0;
        prevValid = 1'b0;
        prevIdx   = '0;
        done      = 1'b0;
        while (!done) begin
            @(posedge clk);
            #5;
            acqStart = 1'b0;
            hitValid = 1'b0;
            if (binValid) begin
                assert (wordCnt < `HIS_NUM_BINS)
                    else stopOnError("more bin words than bins in one sweep");
                expectValue("binOut.idx", 32'(wordCnt), 32'(binOut.idx));
                expectValue("binOut.count", expCount[wordCnt], 32'(binOut.count));
                wordCnt++;
                if (wordCnt == 10) begin
                    acqStart = 1'b1; // restart attempt mid sweep
                    hitValid = 1'b1;
                    hitAddr  = `HIS_NB'(`HIS_NUM_BINS - 1); // bin not swept yet
                end
            end
            if (hisDone) begin
                assert (prevValid && prevIdx == `HIS_NB'(`HIS_NUM_BINS - 1))
                    else stopOnError("hisDone did not follow the last bin word by one cycle");
                expectValue("binValid words", `HIS_NUM_BINS, 32'(wordCnt));
                expectValue("ovfCount", expOvf, 32'(ovfCount));
                expectValue("nextFlag", 32'(!flagBefore), 32'(nextFlag));
                done = 1'b1;
            end
            prevValid = binValid;
            prevIdx   = binOut.idx;
        end
    endtask

    initial begin
        void'($urandom(15));
        clk      = 1'b0;
        res      = 1'b0;
        acqStart = 1'b0;
        hitValid = 1'b0;
        hitAddr  = '0;
        fillTable();
        repeat (2) @(posedge clk);
        #5;
        res = 1'b1;
        expectValue("binValid", 0, 32'(binValid));
        expectValue("hisDone", 0, 32'(hisDone));
        expectValue("nextFlag", 0, 32'(nextFlag));
        expectValue("ovfCount", 0, 32'(ovfCount));
        for (int w = 0; w < NumWin; w++) begin
            buildModel(w);
            runWindow(w);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
rtl/hisDataPkg.sv
rtl/hisCtrlPkg.sv
rtl/binAddrCapture.sv
rtl/hisAccumulator.sv
rtl/hisReadout.sv
rtl/hisBuilder.sv
dv/hisBuilder_chk.sv
dv/hisBuilderTb.sv
